// File: hw/replay_config.svh
// Replay ingest configuration
`ifndef REPLAY_CONFIG_SVH
`define REPLAY_CONFIG_SVH

// AXI-Stream beat data width
`define REPLAY_DATA_W 128

// Sideband width, low 64 bits go into the descriptor
`define REPLAY_USER_W 64

// One strobe bit per data byte
`define REPLAY_STRB_W (`REPLAY_DATA_W / 8)

// Input skid FIFO holds 4 beats
`define REPLAY_SKID_DEPTH_BITS 2

// 16 lines per replay queue
`define REPLAY_QBUF_DEPTH_BITS 4

// Queue split LFSR start value, must be non-zero
`define REPLAY_LFSR_SEED 32'hFFFF_FFFF

`endif

// File: hw/replay_line_pkg.sv
// Replay memory line types
`default_nettype none

`include "replay_config.svh"

package replay_line_pkg;

  // Descriptor view, timestamp in the upper half
  typedef struct packed {
    logic [63:0] timestamp;
    logic [63:0] user_meta;
  } desc_line_t;

  // One memory line, decoded as descriptor or as raw beat data
  typedef union packed {
    desc_line_t                desc;
    logic [`REPLAY_DATA_W-1:0] payload;
  } replay_line_u;

  // Queue buffer word, 146 bits
  typedef struct packed {
    replay_line_u              line;
    logic [`REPLAY_STRB_W-1:0] strb;
    logic                      is_desc;
    logic                      is_last;
  } line_entry_t;

endpackage

`default_nettype wire

// File: hw/replay_queue_pkg.sv
// Replay queue types
`default_nettype none

package replay_queue_pkg;

  // Three split ratios give exactly four queues
  localparam int NUM_QUEUES = 4;

  // Queue index
  typedef logic [1:0] qid_t;

  // Line packer phases
  typedef enum logic {
    WR_DESC,
    WR_DATA
  } packer_state_e;

endpackage

`default_nettype wire

// File: hw/ingest_skid_fifo.sv
// Ingest skid FIFO
`default_nettype none

`include "replay_config.svh"

module ingest_skid_fifo (
  input  wire                          axi_aclk,
  input  wire                          axi_aresetn,
  input  wire  [`REPLAY_DATA_W-1:0]    s_axis_tdata,
  input  wire  [`REPLAY_STRB_W-1:0]    s_axis_tstrb,
  input  wire  [`REPLAY_USER_W-1:0]    s_axis_tuser,
  input  wire                          s_axis_tvalid,
  input  wire                          s_axis_tlast,
  output logic                         s_axis_tready,
  input  wire                          head_pop,
  output logic                         head_valid,
  output logic [`REPLAY_DATA_W-1:0]    head_tdata,
  output logic [`REPLAY_STRB_W-1:0]    head_tstrb,
  output logic [`REPLAY_USER_W-1:0]    head_tuser,
  output logic                         head_tlast
);

  localparam int DEPTH = 1 << `REPLAY_SKID_DEPTH_BITS;

  // Beat storage, one array per field
  logic [`REPLAY_DATA_W-1:0] tdata_mem [DEPTH];
  logic [`REPLAY_STRB_W-1:0] tstrb_mem [DEPTH];
  logic [`REPLAY_USER_W-1:0] tuser_mem [DEPTH];
  logic                      tlast_mem [DEPTH];

  logic [`REPLAY_SKID_DEPTH_BITS-1:0] wr_ptr;
  logic [`REPLAY_SKID_DEPTH_BITS-1:0] rd_ptr;
  logic [`REPLAY_SKID_DEPTH_BITS:0]   count;
  logic                               push;
  logic                               pop;

  // Nearly full at one free slot, leaves room for a beat in flight
  assign s_axis_tready = (count < (DEPTH - 1));
  assign push          = s_axis_tvalid && s_axis_tready;
  assign head_valid    = (count != '0);
  assign pop           = head_pop && head_valid;

  // Fall-through head
  assign head_tdata = tdata_mem[rd_ptr];
  assign head_tstrb = tstrb_mem[rd_ptr];
  assign head_tuser = tuser_mem[rd_ptr];
  assign head_tlast = tlast_mem[rd_ptr];

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      tdata_mem[wr_ptr] <= s_axis_tdata;
      tstrb_mem[wr_ptr] <= s_axis_tstrb;
      tuser_mem[wr_ptr] <= s_axis_tuser;
      tlast_mem[wr_ptr] <= s_axis_tlast;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      // Occupancy only moves on an unmatched push or pop
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Packer must wait for a valid head before popping
  a_no_pop_empty: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) head_pop |-> head_valid);

endmodule

`default_nettype wire

// File: hw/pcap_line_packer.sv
// Packet to memory line packer
`default_nettype none

`include "replay_config.svh"

module pcap_line_packer (
  input  wire                                         axi_aclk,
  input  wire                                         axi_aresetn,
  input  wire                                         head_valid,
  input  wire  [`REPLAY_DATA_W-1:0]                   head_tdata,
  input  wire  [`REPLAY_STRB_W-1:0]                   head_tstrb,
  input  wire  [`REPLAY_USER_W-1:0]                   head_tuser,
  input  wire                                         head_tlast,
  output logic                                        head_pop,
  input  wire  [31:0]                                 split_ratio_0,
  input  wire  [31:0]                                 split_ratio_1,
  input  wire  [31:0]                                 split_ratio_2,
  input  wire  [replay_queue_pkg::NUM_QUEUES-1:0]     buf_full,
  output replay_line_pkg::line_entry_t                wr_entry,
  output logic [replay_queue_pkg::NUM_QUEUES-1:0]     wr_en,
  output logic                                        beat_strb_ok,
  output logic                                        last_strb_ok
);

  import replay_line_pkg::*;
  import replay_queue_pkg::*;

  packer_state_e state;
  packer_state_e next_state;
  qid_t          qid_reg;
  qid_t          sel_qid;
  qid_t          tgt_qid;
  logic          go;
  logic [63:0]   timestamp;
  logic [31:0]   lfsr;
  logic          beat_strb_ok_next;
  logic          last_strb_ok_next;

  // Split by LFSR against the three ratio thresholds
  always_comb begin
    if (lfsr <= split_ratio_0) sel_qid = 2'd0;
    else if (lfsr <= split_ratio_1) sel_qid = 2'd1;
    else if (lfsr <= split_ratio_2) sel_qid = 2'd2;
    else sel_qid = 2'd3;
  end

  // Descriptor targets the fresh pick, data the latched queue
  assign tgt_qid = (state == WR_DESC) ? sel_qid : qid_reg;
  assign go      = head_valid && !buf_full[tgt_qid];

  always_comb begin
    next_state        = state;
    head_pop          = 1'b0;
    wr_en             = '0;
    beat_strb_ok_next = beat_strb_ok;
    last_strb_ok_next = last_strb_ok;

    // Default line is the payload view of the head beat
    wr_entry.line.payload = head_tdata;
    wr_entry.strb         = '0;
    wr_entry.is_desc      = 1'b0;
    wr_entry.is_last      = 1'b0;

    case (state)
      WR_DESC: begin
        // Head beat stays in the skid FIFO for the data phase
        wr_entry.line.desc.timestamp = timestamp;
        wr_entry.line.desc.user_meta = head_tuser[63:0];
        wr_entry.is_desc             = 1'b1;
        if (go) begin
          wr_en[tgt_qid] = 1'b1;
          next_state     = WR_DATA;
        end
      end

      WR_DATA: begin
        wr_entry.is_last = head_tlast;
        // Only the closing line keeps its byte strobe
        if (head_tlast) wr_entry.strb = head_tstrb;
        if (go) begin
          wr_en[tgt_qid] = 1'b1;
          head_pop       = 1'b1;
          if (!head_tlast && (head_tstrb != {`REPLAY_STRB_W{1'b1}})) beat_strb_ok_next = 1'b0;
          if (head_tlast && (head_tstrb == '0)) last_strb_ok_next = 1'b0;
          if (head_tlast) next_state = WR_DESC;
        end
      end

      default: next_state = WR_DESC;
    endcase
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state        <= WR_DESC;
      qid_reg      <= '0;
      timestamp    <= '0;
      lfsr         <= `REPLAY_LFSR_SEED;
      beat_strb_ok <= 1'b1;
      last_strb_ok <= 1'b1;
    end else begin
      state <= next_state;
      // Queue latched with the descriptor, held to end of packet
      if (state == WR_DESC && go) qid_reg <= sel_qid;
      timestamp <= timestamp + 64'd1;
      // Fibonacci taps 31, 6, 4, 2, 1, 0
      lfsr <= {lfsr[31] ^ lfsr[6] ^ lfsr[4] ^ lfsr[2] ^ lfsr[1] ^ lfsr[0], lfsr[31:1]};
      beat_strb_ok <= beat_strb_ok_next;
      last_strb_ok <= last_strb_ok_next;
    end
  end

  // Shared write bus reaches at most one queue
  a_wr_onehot: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) $onehot0(wr_en));

  // Buffer full status must hold back the write
  a_wr_not_full: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) (wr_en & buf_full) == '0);

  // No queue change in the middle of a packet
  a_qid_stable: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) (state == WR_DATA) |=> $stable(qid_reg));

endmodule

`default_nettype wire

// File: hw/queue_line_buffer.sv
// Replay queue line buffer
`default_nettype none

`include "replay_config.svh"

module queue_line_buffer (
  input  wire                           axi_aclk,
  input  wire                           axi_aresetn,
  input  wire                           wr_en,
  input  wire replay_line_pkg::line_entry_t wr_entry,
  input  wire                           rd_en,
  output replay_line_pkg::line_entry_t  rd_entry,
  output logic                          full,
  output logic                          empty
);

  import replay_line_pkg::*;

  localparam int DEPTH = 1 << `REPLAY_QBUF_DEPTH_BITS;

  // Line store
  line_entry_t mem [DEPTH];

  logic [`REPLAY_QBUF_DEPTH_BITS-1:0] wr_ptr;
  logic [`REPLAY_QBUF_DEPTH_BITS-1:0] rd_ptr;
  logic [`REPLAY_QBUF_DEPTH_BITS:0]   count;
  logic                               push;
  logic                               pop;

  assign full  = (count == DEPTH);
  assign empty = (count == '0);
  assign push  = wr_en && !full;
  assign pop   = rd_en && !empty;

  // Head visible the cycle after its write
  assign rd_entry = mem[rd_ptr];

  always_ff @(posedge axi_aclk) begin
    if (push) mem[wr_ptr] <= wr_entry;
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Packer side and arbiter side both honor status
  a_no_wr_full: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) wr_en |-> !full);

  a_no_rd_empty: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) rd_en |-> !empty);

endmodule

`default_nettype wire

// File: hw/queue_drain_arbiter.sv
// Queue drain arbiter
`default_nettype none

module queue_drain_arbiter (
  input  wire                                                      axi_aclk,
  input  wire                                                      axi_aresetn,
  input  wire replay_line_pkg::line_entry_t [replay_queue_pkg::NUM_QUEUES-1:0] buf_entry,
  input  wire  [replay_queue_pkg::NUM_QUEUES-1:0]                  buf_empty,
  output logic [replay_queue_pkg::NUM_QUEUES-1:0]                  buf_rd_en,
  input  wire                                                      out_rd_en,
  output logic                                                     out_empty,
  output logic [127:0]                                             out_line,
  output logic [15:0]                                              out_strb,
  output replay_queue_pkg::qid_t                                   out_qid,
  output logic                                                     out_desc,
  output logic                                                     out_last,
  output logic [63:0]                                              out_timestamp,
  output logic [63:0]                                              out_meta
);

  import replay_line_pkg::*;
  import replay_queue_pkg::*;

  qid_t        grant_q;
  logic        pkt_open;
  qid_t        rr_q;
  logic        rr_hit;
  qid_t        cur_q;
  logic        cur_valid;
  line_entry_t head;
  logic        rd_fire;

  // Rotating search, starts after the last served queue
  always_comb begin
    qid_t idx;
    rr_q   = grant_q;
    rr_hit = 1'b0;
    for (int i = 1; i <= NUM_QUEUES; i++) begin
      idx = grant_q + qid_t'(i);
      if (!rr_hit && !buf_empty[idx]) begin
        rr_q   = idx;
        rr_hit = 1'b1;
      end
    end
  end

  // Grant locked while a packet is partly read
  assign cur_q     = pkt_open ? grant_q : rr_q;
  assign cur_valid = pkt_open ? !buf_empty[grant_q] : rr_hit;
  assign head      = buf_entry[cur_q];
  assign rd_fire   = out_rd_en && cur_valid;

  always_comb begin
    buf_rd_en        = '0;
    buf_rd_en[cur_q] = rd_fire;
  end

  // Zero-latency head decode
  assign out_empty     = !cur_valid;
  assign out_qid       = cur_q;
  assign out_line      = head.line.payload;
  assign out_strb      = head.strb;
  assign out_desc      = head.is_desc;
  assign out_last      = head.is_last;
  assign out_timestamp = head.is_desc ? head.line.desc.timestamp : 64'd0;
  assign out_meta      = head.is_desc ? head.line.desc.user_meta : 64'd0;

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      grant_q  <= '0;
      pkt_open <= 1'b0;
    end else if (rd_fire) begin
      grant_q  <= cur_q;
      // Released only by the closing line
      pkt_open <= !head.is_last;
    end
  end

  // Downstream reads only a valid head
  a_no_rd_empty: assert property (
    @(posedge axi_aclk) disable iff (!axi_aresetn) out_rd_en |-> !out_empty);

endmodule

`default_nettype wire

// File: hw/pcap_replay_ingest.sv
// Packet replay ingest top
`default_nettype none

`include "replay_config.svh"

module pcap_replay_ingest (
  input  wire                           axi_aclk,
  input  wire                           axi_aresetn,
  input  wire  [`REPLAY_DATA_W-1:0]     s_axis_tdata,
  input  wire  [`REPLAY_STRB_W-1:0]     s_axis_tstrb,
  input  wire  [`REPLAY_USER_W-1:0]     s_axis_tuser,
  input  wire                           s_axis_tvalid,
  input  wire                           s_axis_tlast,
  output wire                           s_axis_tready,
  input  wire  [31:0]                   split_ratio_0,
  input  wire  [31:0]                   split_ratio_1,
  input  wire  [31:0]                   split_ratio_2,
  input  wire                           out_rd_en,
  output wire                           out_empty,
  output wire  [127:0]                  out_line,
  output wire  [15:0]                   out_strb,
  output wire replay_queue_pkg::qid_t   out_qid,
  output wire                           out_desc,
  output wire                           out_last,
  output wire  [63:0]                   out_timestamp,
  output wire  [63:0]                   out_meta,
  output wire                           beat_strb_ok,
  output wire                           last_strb_ok
);

  import replay_line_pkg::*;
  import replay_queue_pkg::*;

  // Skid FIFO head
  wire                      head_valid;
  wire [`REPLAY_DATA_W-1:0] head_tdata;
  wire [`REPLAY_STRB_W-1:0] head_tstrb;
  wire [`REPLAY_USER_W-1:0] head_tuser;
  wire                      head_tlast;
  wire                      head_pop;

  // Shared write bus and per-queue status
  wire line_entry_t                  wr_entry;
  wire [NUM_QUEUES-1:0]              wr_en;
  wire [NUM_QUEUES-1:0]              buf_full;
  wire [NUM_QUEUES-1:0]              buf_empty;
  wire [NUM_QUEUES-1:0]              buf_rd_en;
  wire line_entry_t [NUM_QUEUES-1:0] buf_entry;

  ingest_skid_fifo u_skid (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .head_pop      (head_pop),
    .head_valid    (head_valid),
    .head_tdata    (head_tdata),
    .head_tstrb    (head_tstrb),
    .head_tuser    (head_tuser),
    .head_tlast    (head_tlast)
  );

  pcap_line_packer u_packer (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .head_valid    (head_valid),
    .head_tdata    (head_tdata),
    .head_tstrb    (head_tstrb),
    .head_tuser    (head_tuser),
    .head_tlast    (head_tlast),
    .head_pop      (head_pop),
    .split_ratio_0 (split_ratio_0),
    .split_ratio_1 (split_ratio_1),
    .split_ratio_2 (split_ratio_2),
    .buf_full      (buf_full),
    .wr_entry      (wr_entry),
    .wr_en         (wr_en),
    .beat_strb_ok  (beat_strb_ok),
    .last_strb_ok  (last_strb_ok)
  );

  // One line buffer per replay queue
  for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_qbuf
    queue_line_buffer u_qbuf (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .wr_en       (wr_en[g]),
      .wr_entry    (wr_entry),
      .rd_en       (buf_rd_en[g]),
      .rd_entry    (buf_entry[g]),
      .full        (buf_full[g]),
      .empty       (buf_empty[g])
    );
  end

  queue_drain_arbiter u_arb (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .buf_entry     (buf_entry),
    .buf_empty     (buf_empty),
    .buf_rd_en     (buf_rd_en),
    .out_rd_en     (out_rd_en),
    .out_empty     (out_empty),
    .out_line      (out_line),
    .out_strb      (out_strb),
    .out_qid       (out_qid),
    .out_desc      (out_desc),
    .out_last      (out_last),
    .out_timestamp (out_timestamp),
    .out_meta      (out_meta)
  );

endmodule

`default_nettype wire

// File: bench/pcap_replay_ingest_tb.sv
// Packet replay ingest testbench
`default_nettype none

`include "replay_config.svh"

module pcap_replay_ingest_tb;

  localparam int MAX_PKT   = 64;
  localparam int MAX_BEATS = 6;
  localparam int TIMEOUT   = 2000;
  localparam int STALL_RUN = 50;
  // Marks a packet whose queue comes from the LFSR draw
  localparam int ANY_Q     = 4;

  logic                      axi_aclk;
  logic                      axi_aresetn;
  logic [`REPLAY_DATA_W-1:0] s_axis_tdata;
  logic [`REPLAY_STRB_W-1:0] s_axis_tstrb;
  logic [`REPLAY_USER_W-1:0] s_axis_tuser;
  logic                      s_axis_tvalid;
  logic                      s_axis_tlast;
  wire                       s_axis_tready;
  logic [31:0]               split_ratio_0;
  logic [31:0]               split_ratio_1;
  logic [31:0]               split_ratio_2;
  logic                      out_rd_en;
  wire                       out_empty;
  wire  [127:0]              out_line;
  wire  [15:0]               out_strb;
  wire  [1:0]                out_qid;
  wire                       out_desc;
  wire                       out_last;
  wire  [63:0]               out_timestamp;
  wire  [63:0]               out_meta;
  wire                       beat_strb_ok;
  wire                       last_strb_ok;

  // Sent packets, indexed by the id in tuser[15:0]
  logic [`REPLAY_DATA_W-1:0] pkt_data [MAX_PKT][MAX_BEATS];
  logic [`REPLAY_STRB_W-1:0] pkt_strb [MAX_PKT][MAX_BEATS];
  logic [`REPLAY_USER_W-1:0] pkt_user [MAX_PKT];
  int                        pkt_len  [MAX_PKT];
  int                        pkt_qid  [MAX_PKT];
  bit                        pkt_seen [MAX_PKT];

  // Per-queue scoreboard state
  int          last_id [4];
  logic [63:0] last_ts [4];
  bit          have_ts [4];
  int          q_pkts  [4];

  // Packet currently on the drain side
  bit in_pkt;
  bit cur_ok;
  int cur_id;
  int cur_beat;
  int cur_q;

  integer seed = 9;
  int     num_sent;
  int     done_cnt;
  int     checks;
  int     errors;
  bit     timed_out;
  bit     drain_en;
  int     cyc;

  pcap_replay_ingest uut (.*);

  initial axi_aclk = 1'b0;
  always #5 axi_aclk = ~axi_aclk;

  task automatic check(input bit ok, input string msg);
    checks++;
    a_check: assert (ok) else begin
      errors++;
      $display("error %0t: %s", $time, msg);
    end
  endtask

  // First edge after release shows the idle state
  a_reset_state: assert property (@(posedge axi_aclk)
    $rose(axi_aresetn) |-> (s_axis_tready && out_empty && beat_strb_ok && last_strb_ok))
    else begin
      errors++;
      $display("error %0t: outputs not in idle state after reset", $time);
    end

  // Strobe flags only come back through reset
  a_beat_sticky: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    !beat_strb_ok |=> !beat_strb_ok)
    else begin
      errors++;
      $display("error %0t: beat_strb_ok rose without reset", $time);
    end

  a_last_sticky: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    !last_strb_ok |=> !last_strb_ok)
    else begin
      errors++;
      $display("error %0t: last_strb_ok rose without reset", $time);
    end

  // Score the line that the next rising edge consumes
  task automatic take_line();
    logic [`REPLAY_STRB_W-1:0] exp_strb;
    bit                        exp_last;
    if (!in_pkt) begin
      cur_id   = int'(out_meta[15:0]);
      cur_q    = int'(out_qid);
      cur_ok   = (cur_id < num_sent) && !pkt_seen[cur_id];
      cur_beat = 0;
      in_pkt   = !out_last;
      check(out_desc, "packet does not start with a descriptor");
      check(!out_last, "descriptor line marked last");
      check(cur_ok, "descriptor for a packet that was never sent");
      if (cur_ok) begin
        pkt_seen[cur_id] = 1'b1;
        check(out_meta == pkt_user[cur_id], "descriptor meta differs from sent tuser");
        check(pkt_qid[cur_id] == ANY_Q || cur_q == pkt_qid[cur_id], "packet in wrong queue");
        check(cur_id > last_id[cur_q], "packet order broken within a queue");
        check(!have_ts[cur_q] || out_timestamp > last_ts[cur_q],
              "descriptor timestamp not increasing within a queue");
        last_id[cur_q] = cur_id;
        last_ts[cur_q] = out_timestamp;
        have_ts[cur_q] = 1'b1;
        q_pkts[cur_q]++;
      end
    end else begin
      exp_last = cur_ok && (cur_beat == pkt_len[cur_id] - 1);
      exp_strb = exp_last ? pkt_strb[cur_id][cur_beat] : '0;
      check(!out_desc, "descriptor inside a packet");
      check(int'(out_qid) == cur_q, "packet lines interleaved with another queue");
      if (cur_ok && cur_beat < pkt_len[cur_id]) begin
        check(out_line == pkt_data[cur_id][cur_beat], "data line differs from sent beat");
        check(out_last == exp_last, "last flag on the wrong line");
        check(out_strb == exp_strb, "line strobe differs from expected");
      end
      cur_beat++;
      if (out_last) begin
        in_pkt = 1'b0;
        done_cnt++;
      end
    end
  endtask

  // Drain skips every third cycle to let queues build up
  always @(negedge axi_aclk) begin
    cyc++;
    out_rd_en = 1'b0;
    if (axi_aresetn && drain_en && !out_empty && (cyc % 3 != 0)) begin
      out_rd_en = 1'b1;
      take_line();
    end
  end

  task automatic send_beat(input logic [`REPLAY_DATA_W-1:0] data,
                           input logic [`REPLAY_STRB_W-1:0] strb,
                           input logic [`REPLAY_USER_W-1:0] user,
                           input bit last);
    int waited;
    s_axis_tdata  = data;
    s_axis_tstrb  = strb;
    s_axis_tuser  = user;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    waited = 0;
    // tready only moves on a rising edge
    while (!s_axis_tready && waited < TIMEOUT) begin
      @(negedge axi_aclk);
      waited++;
    end
    if (!s_axis_tready) begin
      timed_out = 1'b1;
      $display("Timeout: input stayed not ready for a beat at time %0t", $time);
    end else begin
      @(negedge axi_aclk);
    end
    s_axis_tvalid = 1'b0;
  endtask

  // strb_mode 1 gives a partial first beat, 2 a zero last strobe
  task automatic send_packet(input int exp_q, input int strb_mode, input int len);
    logic [`REPLAY_USER_W-1:0] user;
    int                        id;
    int                        n;
    int                        b;
    id = num_sent;
    n  = (len > 0) ? len : 1 + ($unsigned($random(seed)) % MAX_BEATS);
    if (strb_mode == 1 && n < 2) n = 2;
    user = {$random(seed), 16'h0, id[15:0]};
    pkt_len[id]  = n;
    pkt_qid[id]  = exp_q;
    pkt_user[id] = user;
    pkt_seen[id] = 1'b0;
    for (b = 0; b < n; b++) begin
      pkt_data[id][b] = {$random(seed), $random(seed), $random(seed), $random(seed)};
      if (b == n - 1)
        pkt_strb[id][b] = (strb_mode == 2) ? '0 : 16'hFFFF >> ($unsigned($random(seed)) % 16);
      else
        pkt_strb[id][b] = (strb_mode == 1 && b == 0) ? 16'h00FF : '1;
    end
    num_sent++;
    for (b = 0; b < n; b++)
      send_beat(pkt_data[id][b], pkt_strb[id][b], user, b == n - 1);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((done_cnt < num_sent || !out_empty) && waited < TIMEOUT) begin
      @(negedge axi_aclk);
      waited++;
    end
    if (done_cnt < num_sent || !out_empty) begin
      timed_out = 1'b1;
      $display("Timeout: only %0d of %0d packets drained at time %0t",
               done_cnt, num_sent, $time);
    end
  endtask

  // Looks for a long unbroken run of tready low
  task automatic watch_stall(output bit stalled);
    int waited;
    int low_run;
    waited  = 0;
    low_run = 0;
    while (low_run < STALL_RUN && waited < TIMEOUT) begin
      @(negedge axi_aclk);
      waited++;
      low_run = s_axis_tready ? 0 : low_run + 1;
    end
    stalled = (low_run >= STALL_RUN);
  endtask

  task automatic set_ratios(input logic [31:0] r0, input logic [31:0] r1,
                            input logic [31:0] r2);
    split_ratio_0 = r0;
    split_ratio_1 = r1;
    split_ratio_2 = r2;
  endtask

  task automatic apply_reset();
    int q;
    axi_aresetn = 1'b0;
    repeat (5) @(negedge axi_aclk);
    axi_aresetn = 1'b1;
    // Timestamp counter restarts from zero
    for (q = 0; q < 4; q++) have_ts[q] = 1'b0;
    in_pkt = 1'b0;
  endtask

  initial begin
    bit stalled;
    int i;
    int used;
    axi_aresetn   = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tstrb  = '0;
    s_axis_tuser  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    out_rd_en     = 1'b0;
    drain_en      = 1'b0;
    set_ratios('1, '1, '1);
    for (i = 0; i < 4; i++) last_id[i] = -1;
    apply_reset();
    drain_en = 1'b1;

    // Framing, all ratios at maximum send everything to queue 0
    for (i = 0; i < 5; i++) send_packet(0, 0, 0);
    wait_drained();
    // LFSR never reaches zero
    set_ratios('0, '0, '0);
    for (i = 0; i < 5; i++) send_packet(3, 0, 0);
    wait_drained();
    set_ratios('0, '1, '1);
    for (i = 0; i < 5; i++) send_packet(1, 0, 0);
    wait_drained();

    // Back-pressure with the drain stopped
    drain_en = 1'b0;
    set_ratios('1, '1, '1);
    fork
      for (i = 0; i < 8; i++) send_packet(0, 0, MAX_BEATS);
      begin
        watch_stall(stalled);
        check(stalled, "tready did not stay low with the drain stopped");
        drain_en = 1'b1;
      end
    join
    wait_drained();

    // Mixed ratios spread packets over the queues
    q_pkts = '{default: 0};
    set_ratios(32'h4000_0000, 32'h8000_0000, 32'hC000_0000);
    for (i = 0; i < 16; i++) send_packet(ANY_Q, 0, 0);
    wait_drained();
    used = 0;
    for (i = 0; i < 4; i++)
      if (q_pkts[i] > 0) used++;
    check(used > 1, "mixed ratios sent every packet to one queue");

    // Strobe sanity flags
    set_ratios('1, '1, '1);
    send_packet(0, 1, 0);
    wait_drained();
    check(!beat_strb_ok, "beat_strb_ok high after a partial middle strobe");
    check(last_strb_ok, "last_strb_ok cleared by a middle beat");
    send_packet(0, 2, 0);
    wait_drained();
    check(!last_strb_ok, "last_strb_ok high after a zero last strobe");
    send_packet(0, 0, 0);
    wait_drained();
    check(!beat_strb_ok && !last_strb_ok, "strobe flags did not stay low");
    drain_en = 1'b0;
    apply_reset();
    check(beat_strb_ok && last_strb_ok, "strobe flags not restored by reset");
    drain_en = 1'b1;
    send_packet(0, 0, 0);
    wait_drained();

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/replay_line_pkg.sv
hw/replay_queue_pkg.sv
hw/ingest_skid_fifo.sv
hw/pcap_line_packer.sv
hw/queue_line_buffer.sv
hw/queue_drain_arbiter.sv
hw/pcap_replay_ingest.sv
bench/pcap_replay_ingest_tb.sv

// File: Bender.yml
package:
  name: pcap_replay_ingest

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/replay_line_pkg.sv
      - hw/replay_queue_pkg.sv
      - hw/ingest_skid_fifo.sv
      - hw/pcap_line_packer.sv
      - hw/queue_line_buffer.sv
      - hw/queue_drain_arbiter.sv
      - hw/pcap_replay_ingest.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/pcap_replay_ingest_tb.sv
